/* common/rvseed_params.svh */
`ifndef RVSEED_PARAMS_SVH
`define RVSEED_PARAMS_SVH

// datapath width of the core
`define RV_XLEN 64

// word width for the *W operations
`define RV_WORD 32

// byte address bits on the data memory port
`define RV_MEM_AW 16

`endif

/* common/rv_isa_pkg.sv */
`include "rvseed_params.svh"

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0] xword_t;

    typedef enum logic [4:0] {
        OP_ADD    = 5'd0,
        OP_ADDW   = 5'd1,
        OP_SUB    = 5'd2,
        OP_CMP_EQ = 5'd3,   // branch compares
        OP_CMP_NE = 5'd4,
        OP_CMP_LT = 5'd5,
        OP_SLTU   = 5'd6,
        OP_SRA    = 5'd7,
        OP_SLL    = 5'd8,
        OP_SLLW   = 5'd9,
        OP_AND    = 5'd10,
        OP_OR     = 5'd11,
        OP_XOR    = 5'd12,
        OP_MUL    = 5'd13,
        OP_PASS2  = 5'd14,
        OP_DIVU   = 5'd15,  // iterative unit
        OP_REMU   = 5'd16,
        OP_DIVUW  = 5'd17,
        OP_REMW   = 5'd18,
        OP_LOAD   = 5'd19
    } alu_op_t;

    typedef enum logic [2:0] {
        LD_B  = 3'd0,
        LD_BU = 3'd1,
        LD_W  = 3'd2,
        LD_WU = 3'd3,
        LD_D  = 3'd4
    } ld_width_t;

endpackage

/* common/rv_exec_pkg.sv */
`include "rvseed_params.svh"

package rv_exec_pkg;

    // data memory byte address
    typedef logic [`RV_MEM_AW-1:0] maddr_t;

    // issue port controller
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        BUSY = 2'd1,
        DONE = 2'd2
    } ctrl_state_t;

    // iterative divider
    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_FIN  = 2'd2
    } div_state_t;

endpackage

/* design/alu.sv */
`timescale 1ns/1ps
`include "rvseed_params.svh"

module alu
    import rv_isa_pkg::*;
(
    input  alu_op_t op,
    input  xword_t  src1,
    input  xword_t  src2,
    output xword_t  res,
    output logic    taken
);

    xword_t sum;
    xword_t diff;
    xword_t shl;
    logic [5:0] shamt;

    assign shamt = src2[5:0];   // low 6 bits only
    assign sum   = src1 + src2;
    assign diff  = src1 - src2;
    assign shl   = src1 << shamt;

    always_comb begin
        res   = '0;
        taken = 1'b0;
        case (op)
            OP_ADD: begin
                res = sum;
            end
            OP_ADDW: begin
                res = {{(`RV_XLEN-`RV_WORD){1'b0}}, sum[`RV_WORD-1:0]};  // zero extended
            end
            OP_SUB: begin
                res = diff;
            end
            OP_CMP_EQ: begin
                res   = diff;
                taken = (diff == '0);
            end
            OP_CMP_NE: begin
                res   = diff;
                taken = (diff != '0);
            end
            OP_CMP_LT: begin
                res   = diff;
                taken = ($signed(src1) < $signed(src2));
            end
            OP_SLTU: begin
                res = {{(`RV_XLEN-1){1'b0}}, (src1 < src2)};
            end
            OP_SRA: begin
                res = $signed(src1) >>> shamt;
            end
            OP_SLL: begin
                res = shl;
            end
            OP_SLLW: begin
                res = {{(`RV_XLEN-`RV_WORD){1'b0}}, shl[`RV_WORD-1:0]};
            end
            OP_AND: begin
                res = src1 & src2;
            end
            OP_OR: begin
                res = src1 | src2;
            end
            OP_XOR: begin
                res = src1 ^ src2;
            end
            OP_MUL: begin
                res = src1 * src2;  // low half kept
            end
            OP_PASS2: begin
                res = src2;
            end
            OP_LOAD: begin
                res = sum;  // effective address
            end
            default: begin
                res = '0;   // divides run elsewhere
            end
        endcase
    end

endmodule

/* exec/div_unit.sv */
`timescale 1ns/1ps
`include "rvseed_params.svh"

module div_unit
    import rv_isa_pkg::*, rv_exec_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  alu_op_t op,
    input  xword_t  dividend,
    input  xword_t  divisor,
    output logic    done,
    output xword_t  res
);

    div_state_t state;
    alu_op_t    op_q;
    logic [6:0] cnt;        // steps left
    logic       div_zero;
    logic       neg_rem;    // REMW sign follows dividend
    xword_t     quo;
    xword_t     rem;
    xword_t     dvs;

    logic [`RV_XLEN:0]   shifted;
    logic [`RV_XLEN:0]   trial;
    logic [`RV_WORD-1:0] a_mag;
    logic [`RV_WORD-1:0] b_mag;
    logic [`RV_WORD-1:0] rem_w;

    // magnitudes only matter for the signed word remainder
    assign a_mag = (op == OP_REMW && dividend[`RV_WORD-1]) ?
                   -dividend[`RV_WORD-1:0] : dividend[`RV_WORD-1:0];
    assign b_mag = (op == OP_REMW && divisor[`RV_WORD-1]) ?
                   -divisor[`RV_WORD-1:0] : divisor[`RV_WORD-1:0];

    assign shifted = {rem, quo[`RV_XLEN-1]};
    assign trial   = shifted - {1'b0, dvs};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DIV_IDLE;
        end else begin
            case (state)
                DIV_IDLE: if (start) state <= DIV_RUN;
                DIV_RUN:  if (cnt == 7'd1) state <= DIV_FIN;
                default:  state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && start) begin
            op_q    <= op;
            rem     <= '0;
            neg_rem <= (op == OP_REMW) && dividend[`RV_WORD-1];
            if (op == OP_DIVUW || op == OP_REMW) begin
                quo      <= {a_mag, {`RV_WORD{1'b0}}};   // left aligned, 32 steps
                dvs      <= {{(`RV_XLEN-`RV_WORD){1'b0}}, b_mag};
                cnt      <= 7'd32;
                div_zero <= (divisor[`RV_WORD-1:0] == '0);
            end else begin
                quo      <= dividend;
                dvs      <= divisor;
                cnt      <= 7'd64;
                div_zero <= (divisor == '0);
            end
        end else if (state == DIV_RUN) begin
            cnt <= cnt - 7'd1;
            if (!trial[`RV_XLEN]) begin
                rem <= trial[`RV_XLEN-1:0];
                quo <= {quo[`RV_XLEN-2:0], 1'b1};
            end else begin
                rem <= shifted[`RV_XLEN-1:0];
                quo <= {quo[`RV_XLEN-2:0], 1'b0};
            end
        end
    end

    assign done  = (state == DIV_FIN);
    assign rem_w = neg_rem ? -rem[`RV_WORD-1:0] : rem[`RV_WORD-1:0];

    always_comb begin
        case (op_q)
            OP_DIVU:  res = div_zero ? '1 : quo;
            OP_REMU:  res = rem;
            OP_DIVUW: res = {{(`RV_XLEN-`RV_WORD){1'b0}},
                             (div_zero ? {`RV_WORD{1'b1}} : quo[`RV_WORD-1:0])};
            default:  res = {{(`RV_XLEN-`RV_WORD){rem_w[`RV_WORD-1]}}, rem_w};
        endcase
    end

endmodule

/* exec/load_unit.sv */
`timescale 1ns/1ps
`include "rvseed_params.svh"

module load_unit
    import rv_isa_pkg::*, rv_exec_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  xword_t    addr,
    input  ld_width_t ld_width,
    output logic      done,
    output xword_t    res,
    output logic      mem_req,
    output maddr_t    mem_addr,
    input  logic      mem_ack,
    input  xword_t    mem_rdata
);

    logic      wait_fall;   // data taken, waiting for mem_ack low
    logic [2:0] offset;
    ld_width_t width_q;
    xword_t    ext;
    logic [7:0] byte_sel;
    logic [`RV_WORD-1:0] word_sel;

    assign byte_sel = mem_rdata[{offset, 3'b000} +: 8];
    assign word_sel = mem_rdata[{offset[2], 5'b00000} +: `RV_WORD];

    always_comb begin
        case (width_q)
            LD_B:    ext = {{(`RV_XLEN-8){byte_sel[7]}}, byte_sel};
            LD_BU:   ext = {{(`RV_XLEN-8){1'b0}}, byte_sel};
            LD_W:    ext = {{(`RV_XLEN-`RV_WORD){word_sel[`RV_WORD-1]}}, word_sel};
            LD_WU:   ext = {{(`RV_XLEN-`RV_WORD){1'b0}}, word_sel};
            default: ext = mem_rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_req   <= 1'b0;
            wait_fall <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                mem_req <= 1'b1;
            end else if (mem_req && mem_ack) begin
                mem_req   <= 1'b0;
                wait_fall <= 1'b1;
            end else if (wait_fall && !mem_ack) begin
                wait_fall <= 1'b0;
                done      <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mem_addr <= {addr[`RV_MEM_AW-1:3], 3'b000};    // doubleword aligned
            offset   <= addr[2:0];
            width_q  <= ld_width;
        end
        if (mem_req && mem_ack) res <= ext;
    end

endmodule

/* exec/exec_ctrl.sv */
`timescale 1ns/1ps
`include "rvseed_params.svh"

module exec_ctrl
    import rv_isa_pkg::*, rv_exec_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req,
    input  alu_op_t   op,
    input  xword_t    src2,
    input  ld_width_t ld_width,
    output logic      ack,
    output xword_t    res,
    output logic      taken,
    input  xword_t    alu_res,
    input  logic      alu_taken,
    output logic      div_start,
    input  logic      div_done,
    input  xword_t    div_res,
    output logic      ld_start,
    output xword_t    ld_addr,
    input  logic      ld_done,
    input  xword_t    ld_res
);

    ctrl_state_t state;
    logic        is_ld;
    logic        is_div;
    logic        quick_div;     // quotient by zero needs no iteration
    logic        use_div;
    logic        finish;
    xword_t      quick_res;

    assign is_ld  = (op == OP_LOAD) && (ld_width <= LD_D);
    assign is_div = (op == OP_DIVU) || (op == OP_REMU) ||
                    (op == OP_DIVUW) || (op == OP_REMW);
    assign quick_div = ((op == OP_DIVU) && (src2 == '0)) ||
                       ((op == OP_DIVUW) && (src2[`RV_WORD-1:0] == '0));
    assign use_div   = is_div && !quick_div;
    assign quick_res = (op == OP_DIVUW) ?
                       {{(`RV_XLEN-`RV_WORD){1'b0}}, {`RV_WORD{1'b1}}} : '1;

    // ALU and quick divides finish on the first BUSY cycle
    assign finish = (state == BUSY) &&
                    (is_ld ? ld_done : (use_div ? div_done : 1'b1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            ack       <= 1'b0;
            div_start <= 1'b0;
            ld_start  <= 1'b0;
        end else begin
            div_start <= 1'b0;
            ld_start  <= 1'b0;
            case (state)
                IDLE: if (req) begin
                    state     <= BUSY;
                    div_start <= use_div;
                    ld_start  <= is_ld;
                end
                BUSY: if (finish) begin
                    state <= DONE;
                    ack   <= 1'b1;
                end
                DONE: if (!req) begin
                    state <= IDLE;
                    ack   <= 1'b0;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req) ld_addr <= alu_res;
        if (finish) begin
            taken <= alu_taken;     // zero for non-compares
            if (is_ld)          res <= ld_res;
            else if (use_div)   res <= div_res;
            else if (quick_div) res <= quick_res;
            else                res <= alu_res;
        end
    end

endmodule

/* design/exec_top.sv */
`timescale 1ns/1ps
`include "rvseed_params.svh"

module exec_top
    import rv_isa_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  alu_op_t               op,
    input  xword_t                src1,
    input  xword_t                src2,
    input  ld_width_t             ld_width,
    output logic                  ack,
    output xword_t                res,
    output logic                  taken,
    output logic                  mem_req,
    output logic [`RV_MEM_AW-1:0] mem_addr,
    input  logic                  mem_ack,
    input  xword_t                mem_rdata
);

    xword_t alu_res;
    logic   alu_taken;
    logic   div_start;
    logic   div_done;
    xword_t div_res;
    logic   ld_start;
    xword_t ld_addr;
    logic   ld_done;
    xword_t ld_res;

    alu alu_inst (.op(op), .src1(src1), .src2(src2), .res(alu_res), .taken(alu_taken));

    div_unit div_unit_inst (.clk(clk), .rst(rst), .start(div_start), .op(op),
        .dividend(src1), .divisor(src2), .done(div_done), .res(div_res));

    load_unit load_unit_inst (.clk(clk), .rst(rst), .start(ld_start), .addr(ld_addr),
        .ld_width(ld_width), .done(ld_done), .res(ld_res), .mem_req(mem_req),
        .mem_addr(mem_addr), .mem_ack(mem_ack), .mem_rdata(mem_rdata));

    exec_ctrl exec_ctrl_inst (.clk(clk), .rst(rst), .req(req), .op(op), .src2(src2),
        .ld_width(ld_width), .ack(ack), .res(res), .taken(taken), .alu_res(alu_res),
        .alu_taken(alu_taken), .div_start(div_start), .div_done(div_done),
        .div_res(div_res), .ld_start(ld_start), .ld_addr(ld_addr), .ld_done(ld_done),
        .ld_res(ld_res));

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

endmodule

/* test/exec_sva.sv */
`timescale 1ns/1ps
`include "rvseed_params.svh"

module exec_sva (
    input logic                  clk,
    input logic                  rst,
    input logic                  req,
    input logic                  ack,
    input logic                  mem_req,
    input logic [`RV_MEM_AW-1:0] mem_addr
);

    // covers the reset cycles and the one after
    ack_low_in_reset: assert property (@(posedge clk) rst |=> !ack)
        else $error("ack high during or right after reset");

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> req)
        else $error("ack rose without req");

    ack_held: assert property (@(posedge clk) disable iff (rst)
        (ack && req) |=> ack)
        else $error("ack dropped while req still high");

    mem_addr_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req |=> (!mem_req || $stable(mem_addr)))
        else $error("mem_addr changed while mem_req high");

endmodule

bind exec_top exec_sva exec_sva_inst (
    .clk(clk),
    .rst(rst),
    .req(req),
    .ack(ack),
    .mem_req(mem_req),
    .mem_addr(mem_addr)
);

/* test/exec_tb.sv */
`timescale 1ns/1ps
`include "rvseed_params.svh"

module exec_tb
    import rv_isa_pkg::*;
();

    localparam int TIMEOUT = 500;

    logic      clk;
    logic      rst;
    logic      req;
    alu_op_t   op;
    xword_t    src1;
    xword_t    src2;
    ld_width_t ld_width;
    logic      ack;
    xword_t    res;
    logic      taken;
    logic      mem_req;
    logic [`RV_MEM_AW-1:0] mem_addr;
    logic      mem_ack;
    xword_t    mem_rdata;
    logic      mem_armed;
    logic [2:0] mem_wait;

    xword_t corners[6] = '{64'h0, '1, 64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff,
                           64'h1, 64'h0000_0000_8000_0000};
    alu_op_t alu_ops[15] = '{OP_ADD, OP_ADDW, OP_SUB, OP_CMP_EQ, OP_CMP_NE, OP_CMP_LT,
                             OP_SLTU, OP_SRA, OP_SLL, OP_SLLW, OP_AND, OP_OR, OP_XOR,
                             OP_MUL, OP_PASS2};
    alu_op_t div_ops[4] = '{OP_DIVU, OP_REMU, OP_DIVUW, OP_REMW};

    tb_clock tb_clock_inst (.clk(clk));

    exec_top exec_top_inst (.clk(clk), .rst(rst), .req(req), .op(op), .src1(src1),
        .src2(src2), .ld_width(ld_width), .ack(ack), .res(res), .taken(taken),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_ack(mem_ack), .mem_rdata(mem_rdata));

    function automatic logic [7:0] mem_byte(logic [15:0] a);
        return a[7:0] ^ a[15:8] ^ 8'hA5;
    endfunction

    function automatic xword_t dword_at(logic [15:0] a);
        xword_t d;
        for (int i = 0; i < 8; i++) d[i*8 +: 8] = mem_byte(a + 16'(i));
        return d;
    endfunction

    function automatic xword_t load_ref(logic [15:0] ea, ld_width_t w);
        logic [7:0]  b;
        logic [31:0] wd;
        b  = mem_byte(ea);
        wd = {mem_byte(ea + 16'd3), mem_byte(ea + 16'd2), mem_byte(ea + 16'd1), b};
        case (w)
            LD_B:    return {{56{b[7]}}, b};
            LD_BU:   return {56'b0, b};
            LD_W:    return {{32{wd[31]}}, wd};
            LD_WU:   return {32'b0, wd};
            default: return {mem_byte(ea + 16'd7), mem_byte(ea + 16'd6),
                             mem_byte(ea + 16'd5), mem_byte(ea + 16'd4), wd};
        endcase
    endfunction

    function automatic xword_t model_result(alu_op_t o, xword_t a, xword_t b);
        longint sa;
        longint sb;
        longint r;
        xword_t sum;
        sum = a + b;
        case (o)
            OP_ADD:   return sum;
            OP_ADDW:  return {32'b0, sum[31:0]};
            OP_SUB, OP_CMP_EQ, OP_CMP_NE, OP_CMP_LT: return a - b;
            OP_SLTU:  return {63'b0, a < b};
            OP_SRA:   return $signed(a) >>> b[5:0];
            OP_SLL:   return a << b[5:0];
            OP_SLLW:  return {32'b0, a[31:0] << b[5:0]};
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_XOR:   return a ^ b;
            OP_MUL:   return a * b;
            OP_PASS2: return b;
            OP_DIVU:  return (b == 0) ? '1 : a / b;
            OP_REMU:  return (b == 0) ? a : a % b;
            OP_DIVUW: return {32'b0, (b[31:0] == 0) ? 32'hffff_ffff : a[31:0] / b[31:0]};
            OP_REMW: begin
                sa = {{32{a[31]}}, a[31:0]};
                sb = {{32{b[31]}}, b[31:0]};
                if (sa < 0) sa = -sa;   // magnitudes, sign restored below
                if (sb < 0) sb = -sb;
                r = (sb == 0) ? sa : sa % sb;
                if (a[31]) r = -r;
                return r;
            end
            default:  return '0;
        endcase
    endfunction

    function automatic logic model_taken(alu_op_t o, xword_t a, xword_t b);
        case (o)
            OP_CMP_EQ: return a == b;
            OP_CMP_NE: return a != b;
            OP_CMP_LT: return $signed(a) < $signed(b);
            default:   return 1'b0;
        endcase
    endfunction

    function automatic logic [15:0] align_for(logic [15:0] ea, ld_width_t w);
        if (w == LD_D) return {ea[15:3], 3'b000};
        if (w == LD_W || w == LD_WU) return {ea[15:2], 2'b00};
        return ea;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input xword_t exp, input xword_t act);
        stop_run($sformatf("** Error %s: expected %h actual %h", name, exp, act));
    endtask

    // four-phase issue, result checked while ack is high
    task automatic issue(input string name, input alu_op_t o, input xword_t a,
                         input xword_t b, input ld_width_t w, input int hold);
        xword_t exp_r;
        logic   exp_t;
        int     n;
        exp_r = (o == OP_LOAD) ? load_ref(16'(a + b), w) : model_result(o, a, b);
        exp_t = model_taken(o, a, b);
        @(posedge clk);
        op <= o;
        src1 <= a;
        src2 <= b;
        ld_width <= w;
        req <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) stop_run($sformatf("timeout waiting for ack in %s", name));
        end while (!ack);
        for (int i = 0; i <= hold; i++) begin
            if (i > 0) @(negedge clk);
            assert (ack === 1'b1) else stop_run($sformatf("ack fell early in %s", name));
            assert (res === exp_r) else value_error({name, " res"}, exp_r, res);
            assert (taken === exp_t) else value_error({name, " taken"}, 64'(exp_t), 64'(taken));
        end
        @(posedge clk);
        req <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) stop_run($sformatf("timeout waiting for ack low in %s", name));
        end while (ack);
    endtask

    task automatic load_at(input string name, input logic [15:0] ea, input ld_width_t w,
                           input int hold);
        xword_t a;
        a = {$urandom, $urandom};
        issue(name, OP_LOAD, a, {48'b0, ea} - a, w, hold);
    endtask

    // memory model answers after a few cycles
    always @(posedge clk) begin
        if (rst) begin
            mem_ack <= 1'b0;
            mem_armed <= 1'b0;
            mem_wait <= 3'd0;
        end else if (mem_ack) begin
            if (!mem_req) mem_ack <= 1'b0;
        end else if (mem_req) begin
            if (!mem_armed) begin
                mem_armed <= 1'b1;
                mem_wait <= 3'($urandom_range(0, 3));
            end else if (mem_wait == 3'd0) begin
                mem_ack <= 1'b1;
                mem_rdata <= dword_at(mem_addr);
                mem_armed <= 1'b0;
            end else begin
                mem_wait <= mem_wait - 3'd1;
            end
        end else begin
            mem_armed <= 1'b0;
        end
    end

    initial begin
        alu_op_t   o;
        ld_width_t w;
        void'($urandom(32'h8adea92c));
        rst = 1'b1;
        req = 1'b0;
        op = OP_ADD;
        src1 = '0;
        src2 = '0;
        ld_width = LD_D;
        mem_rdata = '0;
        mem_ack = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        foreach (alu_ops[k]) begin
            foreach (corners[i]) foreach (corners[j])
                issue("alu_corner", alu_ops[k], corners[i], corners[j], LD_D, 0);
            repeat (10) issue("alu_random", alu_ops[k], {$urandom, $urandom},
                              {$urandom, $urandom}, LD_D, 0);
        end

        issue("cmp_eq_equal", OP_CMP_EQ, 64'h1234, 64'h1234, LD_D, 0);
        issue("cmp_ne_unequal", OP_CMP_NE, 64'h1234, 64'h1235, LD_D, 0);
        issue("cmp_lt_neg", OP_CMP_LT, -64'sd5, 64'd3, LD_D, 0);
        issue("cmp_lt_neg_rev", OP_CMP_LT, 64'd3, -64'sd5, LD_D, 0);
        issue("cmp_lt_both_neg", OP_CMP_LT, -64'sd9, -64'sd2, LD_D, 0);

        foreach (div_ops[k]) begin
            foreach (corners[i]) foreach (corners[j])
                issue("div_corner", div_ops[k], corners[i], corners[j], LD_D, 0);
            repeat (6) issue("div_random", div_ops[k], {$urandom, $urandom},
                             {32'b0, $urandom}, LD_D, 0);
        end
        issue("remw_neg", OP_REMW, -64'sd7, 64'd2, LD_D, 0);
        issue("remw_neg_both", OP_REMW, -64'sd100, -64'sd7, LD_D, 0);
        issue("remw_zero", OP_REMW, 64'h0000_0000_8000_0005, 64'h0, LD_D, 0);

        repeat (4) begin
            logic [15:0] base;
            base = {13'($urandom), 3'b000};
            for (int i = 0; i < 8; i++) begin
                load_at("load_b", base + 16'(i), LD_B, 0);
                load_at("load_bu", base + 16'(i), LD_BU, 0);
            end
            for (int i = 0; i < 8; i += 4) begin
                load_at("load_w", base + 16'(i), LD_W, 0);
                load_at("load_wu", base + 16'(i), LD_WU, 0);
            end
            load_at("load_d", base, LD_D, 0);
        end

        repeat (60) begin
            o = alu_op_t'($urandom_range(0, 19));
            w = ld_width_t'($urandom_range(0, 4));
            if (o == OP_LOAD) load_at("mix_load", align_for(16'($urandom), w), w,
                                      $urandom_range(0, 5));
            else issue("mix", o, {$urandom, $urandom}, {$urandom, $urandom}, w,
                       $urandom_range(0, 5));
        end

        for (int k = 0; k < 2; k++) begin
            @(posedge clk);
            op <= (k == 0) ? OP_DIVU : OP_LOAD;
            src1 <= 64'h40;
            src2 <= 64'h3;
            ld_width <= LD_D;
            req <= 1'b1;
            repeat (3 + k) @(posedge clk);
            rst <= 1'b1;
            req <= 1'b0;
            repeat (3) @(posedge clk);
            rst <= 1'b0;
            issue("after_reset_div", OP_REMU, 64'd100, 64'd7, LD_D, 1);
            load_at("after_reset_load", 16'h0123, LD_BU, 1);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* files.f */
+incdir+common
common/rv_isa_pkg.sv
common/rv_exec_pkg.sv
design/alu.sv
exec/div_unit.sv
exec/load_unit.sv
exec/exec_ctrl.sv
design/exec_top.sv
test/tb_clock.sv
test/exec_sva.sv
test/exec_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= exec_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "PASS: all tests" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
